//--- verilog/fads_consts.svh
`ifndef FADS_CONSTS_SVH
`define FADS_CONSTS_SVH

// sizes
`define FADS_CHNL          6
`define FADS_DWT           14
`define FADS_MEM           32
`define FADS_ADDR_W        3
`define FADS_US_TICKS      125
`define FADS_CLASS_W       16

// bus map, low 20 address bits only
`define FADS_ADDR_DEC      20
`define FADS_A_SORT_DELAY  20'h00024
`define FADS_A_SORT_DUR    20'h00028
`define FADS_A_REC_ID      20'h00200
`define FADS_A_REC_INT     20'h00204
`define FADS_A_REC_WIDTH   20'h00208
`define FADS_A_REC_CLASS   20'h0020C
`define FADS_A_REC_TIME    20'h00210
`define FADS_A_ENABLED     20'h00300
`define FADS_A_SENSE       20'h00304
`define FADS_A_ADC         20'h00308
// six banks: min/low/high intensity, then min/low/high width
`define FADS_A_THR_BASE    20'h01000
`define FADS_A_THR_STRIDE  20'h00020
`define FADS_THR_BANKS     6

// reset values
`define FADS_DEF_INT_MIN   (-14'sd250)
`define FADS_DEF_INT_LOW   (-14'sd240)
`define FADS_DEF_INT_HIGH  (14'sd500)
`define FADS_DEF_WID_MIN   32'd1
`define FADS_DEF_WID_LOW   32'd4
`define FADS_DEF_WID_HIGH  32'd1000
`define FADS_DEF_ENABLED   6'h0F
`define FADS_DEF_SENSE     3'd0
`define FADS_DEF_DELAY     32'd31250
`define FADS_DEF_DUR       32'd125000

`endif

//--- verilog/fads_pkg.sv
`include "fads_consts.svh"

package fads_pkg;

    // one bit per detector channel
    typedef logic [`FADS_CHNL-1:0] chan_mask_t;

    // thresholds of a single channel
    typedef struct packed {
        logic signed [`FADS_DWT-1:0] int_min;
        logic signed [`FADS_DWT-1:0] int_low;
        logic signed [`FADS_DWT-1:0] int_high;
        logic [`FADS_MEM-1:0]        wid_min;
        logic [`FADS_MEM-1:0]        wid_low;
        logic [`FADS_MEM-1:0]        wid_high;
    } chan_thr_t;

    typedef chan_thr_t [`FADS_CHNL-1:0] thr_bank_t;

    // peak and width of one channel over a droplet
    typedef struct packed {
        logic signed [`FADS_DWT-1:0] peak;
        logic [`FADS_MEM-1:0]        width;
    } chan_meas_t;

    typedef chan_meas_t [`FADS_CHNL-1:0] meas_bank_t;

    // record of the last classified droplet
    typedef struct packed {
        logic [`FADS_MEM-1:0]     id;
        logic [`FADS_MEM-1:0]     peak;
        logic [`FADS_MEM-1:0]     width;
        logic [`FADS_CLASS_W-1:0] cls;
        logic [`FADS_MEM-1:0]     time_us;
    } droplet_rec_t;

    // one bus request
    typedef struct packed {
        logic [`FADS_MEM-1:0] addr;
        logic [`FADS_MEM-1:0] wdata;
        logic                 wen;
        logic                 ren;
    } sys_req_t;

endpackage

//--- verilog/fads_regs.sv
`include "fads_consts.svh"

module fads_regs (
    input  logic                         adc_clk_i,
    input  logic                         fads_reset,
    input  fads_pkg::sys_req_t           req_i,
    input  fads_pkg::droplet_rec_t       rec_i,
    input  logic signed [`FADS_DWT-1:0]  adc_i,
    output fads_pkg::thr_bank_t          thr_o,
    output fads_pkg::chan_mask_t         enabled_o,
    output logic [`FADS_ADDR_W-1:0]      sense_addr_o,
    output logic [`FADS_MEM-1:0]         sort_delay_o,
    output logic [`FADS_MEM-1:0]         sort_dur_o,
    output logic [`FADS_MEM-1:0]         rdata_o,
    output logic                         ack_o
);

    localparam int PAD = `FADS_MEM - `FADS_DWT;

    logic [`FADS_ADDR_DEC-1:0] addr;
    logic [`FADS_ADDR_DEC-1:0] thr_off;
    logic [`FADS_ADDR_W-1:0]   thr_bank;
    logic [`FADS_ADDR_W-1:0]   thr_slot;
    logic                      thr_hit;
    logic [`FADS_MEM-1:0]      thr_word;
    logic [`FADS_MEM-1:0]      rd_next;

    assign addr = req_i.addr[`FADS_ADDR_DEC-1:0];

    // offset into the threshold area picks bank and channel
    assign thr_off  = addr - `FADS_A_THR_BASE;
    assign thr_bank = `FADS_ADDR_W'(thr_off / `FADS_A_THR_STRIDE);
    assign thr_slot = `FADS_ADDR_W'((thr_off % `FADS_A_THR_STRIDE) >> 2);
    // word aligned, inside the six banks, slot is a real channel
    assign thr_hit  = (addr >= `FADS_A_THR_BASE)
                   && (thr_off < `FADS_THR_BANKS * `FADS_A_THR_STRIDE)
                   && (thr_off[1:0] == 2'b00)
                   && (thr_slot < `FADS_CHNL);

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            for (int c = 0; c < `FADS_CHNL; c++) begin
                thr_o[c].int_min  <= `FADS_DEF_INT_MIN;
                thr_o[c].int_low  <= `FADS_DEF_INT_LOW;
                thr_o[c].int_high <= `FADS_DEF_INT_HIGH;
                thr_o[c].wid_min  <= `FADS_DEF_WID_MIN;
                thr_o[c].wid_low  <= `FADS_DEF_WID_LOW;
                thr_o[c].wid_high <= `FADS_DEF_WID_HIGH;
            end
            enabled_o    <= `FADS_DEF_ENABLED;
            sense_addr_o <= `FADS_DEF_SENSE;
            sort_delay_o <= `FADS_DEF_DELAY;
            sort_dur_o   <= `FADS_DEF_DUR;
        end else if (req_i.wen) begin
            case (addr)
                `FADS_A_SORT_DELAY: sort_delay_o <= req_i.wdata;
                `FADS_A_SORT_DUR:   sort_dur_o   <= req_i.wdata;
                `FADS_A_ENABLED:    enabled_o    <= req_i.wdata[`FADS_CHNL-1:0];
                `FADS_A_SENSE:      sense_addr_o <= req_i.wdata[`FADS_ADDR_W-1:0];
                default: begin
                    // intensity banks keep only the adc width
                    if (thr_hit) begin
                        case (thr_bank)
                            0: thr_o[thr_slot].int_min  <= req_i.wdata[`FADS_DWT-1:0];
                            1: thr_o[thr_slot].int_low  <= req_i.wdata[`FADS_DWT-1:0];
                            2: thr_o[thr_slot].int_high <= req_i.wdata[`FADS_DWT-1:0];
                            3: thr_o[thr_slot].wid_min  <= req_i.wdata;
                            4: thr_o[thr_slot].wid_low  <= req_i.wdata;
                            default: thr_o[thr_slot].wid_high <= req_i.wdata;
                        endcase
                    end
                end
            endcase
        end
    end

    // threshold readback, zero extended
    always_comb begin
        case (thr_bank)
            0: thr_word = {{PAD{1'b0}}, thr_o[thr_slot].int_min};
            1: thr_word = {{PAD{1'b0}}, thr_o[thr_slot].int_low};
            2: thr_word = {{PAD{1'b0}}, thr_o[thr_slot].int_high};
            3: thr_word = thr_o[thr_slot].wid_min;
            4: thr_word = thr_o[thr_slot].wid_low;
            default: thr_word = thr_o[thr_slot].wid_high;
        endcase
    end

    always_comb begin
        rd_next = '0;
        case (addr)
            `FADS_A_SORT_DELAY: rd_next = sort_delay_o;
            `FADS_A_SORT_DUR:   rd_next = sort_dur_o;
            `FADS_A_REC_ID:     rd_next = rec_i.id;
            `FADS_A_REC_INT:    rd_next = rec_i.peak;
            `FADS_A_REC_WIDTH:  rd_next = rec_i.width;
            `FADS_A_REC_CLASS:  rd_next = `FADS_MEM'(rec_i.cls);
            `FADS_A_REC_TIME:   rd_next = rec_i.time_us;
            `FADS_A_ENABLED:    rd_next = `FADS_MEM'(enabled_o);
            `FADS_A_SENSE:      rd_next = `FADS_MEM'(sense_addr_o);
            // live sample, raw bits
            `FADS_A_ADC:        rd_next = {{PAD{1'b0}}, adc_i};
            default: begin
                if (thr_hit) begin
                    rd_next = thr_word;
                end
            end
        endcase
    end

    // every request acked one cycle later, unmapped ones too
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req_i.wen | req_i.ren;
        end
    end

    always_ff @(posedge adc_clk_i) begin
        if (req_i.wen | req_i.ren) begin
            rdata_o <= rd_next;
        end
    end

endmodule

//--- verilog/fads_acquire.sv
`include "fads_consts.svh"

module fads_acquire (
    input  logic                         adc_clk_i,
    input  logic                         fads_reset,
    input  logic signed [`FADS_DWT-1:0]  adc_i,
    input  logic [`FADS_ADDR_W-1:0]      mux_addr_i,
    input  logic                         stable_i,
    input  fads_pkg::thr_bank_t          thr_i,
    input  fads_pkg::chan_mask_t         enabled_i,
    input  logic [`FADS_ADDR_W-1:0]      sense_addr_i,
    input  logic                         busy_i,
    output fads_pkg::meas_bank_t         meas_o,
    output fads_pkg::chan_mask_t         measured_o,
    output logic                         done_o,
    output fads_pkg::chan_mask_t         mux_ch_o
);

    typedef enum logic [1:0] {
        ST_WAIT,
        ST_ACQ,
        ST_DONE
    } state_t;

    state_t               state;
    fads_pkg::chan_mask_t sense_oh;
    logic                 ch_valid;
    logic                 above;
    logic                 on_sense;
    logic                 start;
    logic                 finish;

    assign sense_oh = fads_pkg::chan_mask_t'(1) << sense_addr_i;

    // channels 6 and 7 of the mux carry nothing
    assign ch_valid = mux_addr_i < `FADS_CHNL;
    assign above    = ch_valid && (adc_i >= thr_i[mux_addr_i].int_min);
    assign on_sense = stable_i && (mux_addr_i == sense_addr_i);

    // droplet edges seen on the sensing channel only
    assign start  = (state == ST_WAIT) && !busy_i && on_sense && above;
    assign finish = (state == ST_ACQ) && on_sense && !above;

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            state <= ST_WAIT;
        end else begin
            case (state)
                ST_WAIT: begin
                    if (start) begin
                        state <= ST_ACQ;
                    end
                end
                ST_ACQ: begin
                    if (finish) begin
                        state <= ST_DONE;
                    end
                end
                // single cycle, evaluation happens here
                default: state <= ST_WAIT;
            endcase
        end
    end

    always_ff @(posedge adc_clk_i) begin
        if (start) begin
            // fresh droplet, peaks start from most negative code
            for (int c = 0; c < `FADS_CHNL; c++) begin
                meas_o[c].peak  <= {1'b1, {(`FADS_DWT-1){1'b0}}};
                meas_o[c].width <= '0;
            end
            meas_o[sense_addr_i].peak  <= adc_i;
            meas_o[sense_addr_i].width <= `FADS_MEM'(1);
            measured_o <= enabled_i | sense_oh;
        end else if ((state == ST_ACQ) && stable_i && ch_valid) begin
            if (adc_i > meas_o[mux_addr_i].peak) begin
                meas_o[mux_addr_i].peak <= adc_i;
            end
            // width counts samples over the channel min
            if (above) begin
                meas_o[mux_addr_i].width <= meas_o[mux_addr_i].width + `FADS_MEM'(1);
            end
        end
    end

    assign done_o = (state == ST_DONE);

    // idle mux parks on the sensing detector
    assign mux_ch_o = (state == ST_WAIT) ? sense_oh : measured_o;

endmodule

//--- verilog/fads_evaluate.sv
`include "fads_consts.svh"

module fads_evaluate (
    input  logic                     adc_clk_i,
    input  logic                     fads_reset,
    input  fads_pkg::meas_bank_t     meas_i,
    input  fads_pkg::chan_mask_t     measured_i,
    input  logic                     done_i,
    input  fads_pkg::thr_bank_t      thr_i,
    input  logic [`FADS_ADDR_W-1:0]  sense_addr_i,
    output fads_pkg::droplet_rec_t   rec_o,
    output logic                     sort_req_o
);

    localparam int PRE_W = $clog2(`FADS_US_TICKS);

    fads_pkg::chan_mask_t int_low, int_pos, int_high;
    fads_pkg::chan_mask_t wid_low, wid_pos, wid_high;
    logic [`FADS_CLASS_W-1:0] cls;
    logic                     positive;
    logic                     negative;
    logic [PRE_W-1:0]         us_pre;
    logic [`FADS_MEM-1:0]     us_cnt;

    // band flags per channel
    always_comb begin
        for (int c = 0; c < `FADS_CHNL; c++) begin
            int_low[c]  = (meas_i[c].peak >= thr_i[c].int_min)
                       && (meas_i[c].peak < thr_i[c].int_low);
            int_pos[c]  = (meas_i[c].peak >= thr_i[c].int_low)
                       && (meas_i[c].peak < thr_i[c].int_high);
            int_high[c] = meas_i[c].peak >= thr_i[c].int_high;
            // every width band needs the min width
            wid_low[c]  = (meas_i[c].width >= thr_i[c].wid_min)
                       && (meas_i[c].width < thr_i[c].wid_low);
            wid_pos[c]  = (meas_i[c].width >= thr_i[c].wid_min)
                       && (meas_i[c].width >= thr_i[c].wid_low)
                       && (meas_i[c].width < thr_i[c].wid_high);
            wid_high[c] = (meas_i[c].width >= thr_i[c].wid_min)
                       && (meas_i[c].width >= thr_i[c].wid_high);
        end
    end

    // reductions skip channels not measured
    always_comb begin
        cls     = '0;
        cls[0]  = |(int_low & measured_i);
        cls[1]  = &(int_pos | ~measured_i);
        cls[2]  = |(int_high & measured_i);
        cls[3]  = |(wid_low & measured_i);
        cls[4]  = &(wid_pos | ~measured_i);
        cls[5]  = |(wid_high & measured_i);
        positive = cls[1] && cls[4];
        cls[15] = positive;
        negative = |((int_low | int_pos | int_high) & measured_i)
                && |((wid_low | wid_pos | wid_high) & measured_i)
                && !positive;
    end

    // free running microsecond time base
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            us_pre <= '0;
            us_cnt <= '0;
        end else if (us_pre == PRE_W'(`FADS_US_TICKS - 1)) begin
            us_pre <= '0;
            us_cnt <= us_cnt + `FADS_MEM'(1);
        end else begin
            us_pre <= us_pre + PRE_W'(1);
        end
    end

    // unclassified droplets leave the record alone
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            rec_o      <= '0;
            sort_req_o <= 1'b0;
        end else begin
            sort_req_o <= done_i && positive;
            if (done_i && (positive || negative)) begin
                rec_o.id      <= rec_o.id + `FADS_MEM'(1);
                // peak sign extended to bus width
                rec_o.peak    <= `FADS_MEM'(meas_i[sense_addr_i].peak);
                rec_o.width   <= meas_i[sense_addr_i].width;
                rec_o.cls     <= cls;
                rec_o.time_us <= us_cnt;
            end
        end
    end

endmodule

//--- verilog/fads_sort_pulse.sv
`include "fads_consts.svh"

module fads_sort_pulse (
    input  logic                  adc_clk_i,
    input  logic                  fads_reset,
    input  logic                  req_i,
    input  logic [`FADS_MEM-1:0]  delay_i,
    input  logic [`FADS_MEM-1:0]  dur_i,
    output logic                  trig_o,
    output logic                  busy_o
);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_DELAY,
        PH_FIRE
    } phase_t;

    phase_t               phase;
    logic [`FADS_MEM-1:0] cnt;

    // cnt holds cycles left in the current phase
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            phase <= PH_IDLE;
            cnt   <= '0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (req_i && (delay_i != '0)) begin
                        phase <= PH_DELAY;
                        cnt   <= delay_i;
                    end else if (req_i && (dur_i != '0)) begin
                        // zero delay fires straight away
                        phase <= PH_FIRE;
                        cnt   <= dur_i;
                    end
                end
                PH_DELAY: begin
                    if (cnt > `FADS_MEM'(1)) begin
                        cnt <= cnt - `FADS_MEM'(1);
                    end else if (dur_i != '0) begin
                        phase <= PH_FIRE;
                        cnt   <= dur_i;
                    end else begin
                        phase <= PH_IDLE;
                    end
                end
                default: begin
                    if (cnt > `FADS_MEM'(1)) begin
                        cnt <= cnt - `FADS_MEM'(1);
                    end else begin
                        phase <= PH_IDLE;
                    end
                end
            endcase
        end
    end

    assign trig_o = (phase == PH_FIRE);

    // request counts too, acquisition must not restart under it
    assign busy_o = req_i || (phase != PH_IDLE);

endmodule

//--- verilog/fads_top.sv
module fads_top (
    input  logic                  adc_clk_i,
    input  logic                  fads_reset,
    input  logic signed [13:0]    adc_a_i,
    input  logic [2:0]            mux_addr_i,
    input  logic                  signal_stable_i,
    input  logic [31:0]           sys_addr_i,
    input  logic [31:0]           sys_wdata_i,
    input  logic                  sys_wen_i,
    input  logic                  sys_ren_i,
    output logic [31:0]           sys_rdata_o,
    output logic                  sys_ack_o,
    output logic                  sort_trig_o,
    output fads_pkg::chan_mask_t  muxing_channels_o
);

    fads_pkg::sys_req_t     req;
    fads_pkg::droplet_rec_t rec;
    fads_pkg::thr_bank_t    thr;
    fads_pkg::meas_bank_t   meas;
    fads_pkg::chan_mask_t   enabled;
    fads_pkg::chan_mask_t   measured;
    logic [2:0]             sense_addr;
    logic [31:0]            sort_delay;
    logic [31:0]            sort_dur;
    logic                   meas_done;
    logic                   sort_req;
    logic                   sort_busy;

    assign req = '{addr: sys_addr_i, wdata: sys_wdata_i, wen: sys_wen_i, ren: sys_ren_i};

    fads_regs u_regs (
        .adc_clk_i    (adc_clk_i),
        .fads_reset   (fads_reset),
        .req_i        (req),
        .rec_i        (rec),
        .adc_i        (adc_a_i),
        .thr_o        (thr),
        .enabled_o    (enabled),
        .sense_addr_o (sense_addr),
        .sort_delay_o (sort_delay),
        .sort_dur_o   (sort_dur),
        .rdata_o      (sys_rdata_o),
        .ack_o        (sys_ack_o)
    );

    fads_acquire u_acquire (
        .adc_clk_i    (adc_clk_i),
        .fads_reset   (fads_reset),
        .adc_i        (adc_a_i),
        .mux_addr_i   (mux_addr_i),
        .stable_i     (signal_stable_i),
        .thr_i        (thr),
        .enabled_i    (enabled),
        .sense_addr_i (sense_addr),
        .busy_i       (sort_busy),
        .meas_o       (meas),
        .measured_o   (measured),
        .done_o       (meas_done),
        .mux_ch_o     (muxing_channels_o)
    );

    // record picks its peak and width from the sensing channel
    fads_evaluate u_evaluate (
        .adc_clk_i    (adc_clk_i),
        .fads_reset   (fads_reset),
        .meas_i       (meas),
        .measured_i   (measured),
        .done_i       (meas_done),
        .thr_i        (thr),
        .sense_addr_i (sense_addr),
        .rec_o        (rec),
        .sort_req_o   (sort_req)
    );

    fads_sort_pulse u_sort (
        .adc_clk_i  (adc_clk_i),
        .fads_reset (fads_reset),
        .req_i      (sort_req),
        .delay_i    (sort_delay),
        .dur_i      (sort_dur),
        .trig_o     (sort_trig_o),
        .busy_o     (sort_busy)
    );

endmodule

//--- testbench/tb_clock.sv
module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // reset held for five rising edges, released on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

//--- testbench/tb_fads.sv
`include "fads_consts.svh"

module tb_fads;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROWS  = 8;
    localparam int DELAY = 3;
    localparam int DUR   = 5;
    localparam int IDLE  = 300;
    // thresholds written to every channel
    localparam int T_IMIN = 100;
    localparam int T_ILOW = 200;
    localparam int T_IHIGH = 1000;
    localparam int T_WMIN = 2;
    localparam int T_WLOW = 3;
    localparam int T_WHIGH = 8;

    // droplet table, sensing channel is 0
    localparam logic [5:0] ROW_EN [ROWS] = '{6'h01, 6'h01, 6'h01, 6'h03,
                                             6'h03, 6'h01, 6'h03, 6'h0F};
    localparam int ROW_N [ROWS] = '{4, 4, 10, 4, 5, 1, 1, 3};
    localparam int ROW_PEAK [ROWS][6] = '{
        '{500, 0, 0, 0, 0, 0},
        '{150, 0, 0, 0, 0, 0},
        '{500, 0, 0, 0, 0, 0},
        '{500, 1200, 0, 0, 0, 0},
        '{500, 600, 0, 0, 0, 0},
        '{500, 0, 0, 0, 0, 0},
        '{300, 50, 0, 0, 0, 0},
        '{400, 450, 300, 999, 0, 0}
    };
    localparam logic [15:0] ROW_CLS [ROWS] = '{16'h8012, 16'h0011, 16'h0022, 16'h0014,
                                               16'h8012, 16'h0002, 16'h0000, 16'h8012};
    localparam bit ROW_POS [ROWS]  = '{1, 0, 0, 0, 1, 0, 0, 1};
    localparam bit ROW_SORT [ROWS] = '{1, 0, 0, 0, 1, 0, 0, 1};

    logic                 clk;
    logic                 rst;
    logic signed [13:0]   adc;
    logic [2:0]           mux_addr;
    logic                 stable;
    logic [31:0]          sys_addr;
    logic [31:0]          sys_wdata;
    logic                 wen;
    logic                 ren;
    logic [31:0]          rdata;
    logic                 ack;
    logic                 trig;
    fads_pkg::chan_mask_t mux_ch;

    int          errors;
    int          test_err;
    int          tests_ok;
    int          tests_bad;
    logic [15:0] lfsr;
    longint      cycle;

    tb_clock u_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    fads_top u_dut (
        .adc_clk_i         (clk),
        .fads_reset        (rst),
        .adc_a_i           (adc),
        .mux_addr_i        (mux_addr),
        .signal_stable_i   (stable),
        .sys_addr_i        (sys_addr),
        .sys_wdata_i       (sys_wdata),
        .sys_wen_i         (wen),
        .sys_ren_i         (ren),
        .sys_rdata_o       (rdata),
        .sys_ack_o         (ack),
        .sort_trig_o       (trig),
        .muxing_channels_o (mux_ch)
    );

    // rising edges since start
    initial cycle = 0;
    always @(posedge clk) cycle <= cycle + 1;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // baseline noise 0..63, under the min intensity
    task automatic noise_sample(output logic signed [13:0] v);
        v = '0;
        for (int i = 0; i < 6; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[12:0], lfsr[0]};
        end
    endtask

    task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
        errors++;
    endtask

    task automatic fail_text(input string msg);
        $display("%0t error: %s", $time, msg);
        errors++;
    endtask

    function automatic logic [31:0] thr_addr(input int bank, input int ch);
        return 32'(`FADS_A_THR_BASE + bank * `FADS_A_THR_STRIDE + ch * 4);
    endfunction

    // header defaults as seen through the bus
    function automatic logic [31:0] thr_default(input int bank);
        case (bank)
            0: return {18'b0, `FADS_DEF_INT_MIN};
            1: return {18'b0, `FADS_DEF_INT_LOW};
            2: return {18'b0, `FADS_DEF_INT_HIGH};
            3: return `FADS_DEF_WID_MIN;
            4: return `FADS_DEF_WID_LOW;
            default: return `FADS_DEF_WID_HIGH;
        endcase
    endfunction

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        @(negedge clk);
        sys_addr  = a;
        sys_wdata = d;
        wen       = 1'b1;
        @(negedge clk);
        wen = 1'b0;
        if (ack !== 1'b1) begin
            fail_text($sformatf("no ack for write to %h", a));
        end
    endtask

    // ack must be high for exactly the cycle after the request
    task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
        @(negedge clk);
        sys_addr = a;
        ren      = 1'b1;
        @(negedge clk);
        ren = 1'b0;
        d   = rdata;
        if (ack !== 1'b1) begin
            fail_text($sformatf("no ack for read of %h", a));
        end
        @(negedge clk);
        if (ack !== 1'b0) begin
            fail_text($sformatf("ack held past one cycle for read of %h", a));
        end
    endtask

    task automatic read_check(input string name, input logic [31:0] a, input logic [31:0] exp);
        logic [31:0] d;
        bus_read(a, d);
        if (d !== exp) begin
            fail_value(name, d, exp);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_err) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - test_err);
        end
        test_err = errors;
    endtask

    // band rules applied to the row's ideal measurements
    function automatic logic [15:0] model_class(input int r, output bit pos, output bit neg);
        logic [5:0] meas;
        int  pk;
        int  w;
        bit  il, ip, ih, wl, wp, wh;
        bit  any_il, all_ip, any_ih, any_wl, all_wp, any_wh, any_ib, any_wb;
        meas   = ROW_EN[r] | 6'h01;
        any_il = 0;
        all_ip = 1;
        any_ih = 0;
        any_wl = 0;
        all_wp = 1;
        any_wh = 0;
        any_ib = 0;
        any_wb = 0;
        for (int c = 0; c < 6; c++) begin
            if (meas[c]) begin
                pk = ROW_PEAK[r][c];
                // samples under min never count
                w  = (pk >= T_IMIN) ? ROW_N[r] : 0;
                il = (pk >= T_IMIN) && (pk < T_ILOW);
                ip = (pk >= T_ILOW) && (pk < T_IHIGH);
                ih = pk >= T_IHIGH;
                wl = (w >= T_WMIN) && (w < T_WLOW);
                wp = (w >= T_WMIN) && (w >= T_WLOW) && (w < T_WHIGH);
                wh = (w >= T_WMIN) && (w >= T_WHIGH);
                any_il |= il;
                all_ip &= ip;
                any_ih |= ih;
                any_wl |= wl;
                all_wp &= wp;
                any_wh |= wh;
                any_ib |= il | ip | ih;
                any_wb |= wl | wp | wh;
            end
        end
        pos = all_ip && all_wp;
        neg = any_ib && any_wb && !pos;
        return {pos, 9'b0, any_wh, all_wp, any_wl, any_ih, all_ip, any_il};
    endfunction

    // drives one droplet, returns the cycle number of the end sample edge
    task automatic drive_droplet(input int r, output longint e_cycle);
        logic [5:0]         meas;
        logic signed [13:0] n;
        meas = ROW_EN[r] | 6'h01;
        repeat (IDLE) begin
            @(negedge clk);
            noise_sample(n);
            mux_addr = 3'd0;
            adc      = n;
            stable   = 1'b1;
            if (mux_ch !== 6'h01) begin
                fail_value("muxing_channels_o", 32'(mux_ch), 32'h01);
            end
        end
        for (int k = 0; k < ROW_N[r]; k++) begin
            for (int c = 0; c < 6; c++) begin
                if (meas[c]) begin
                    @(negedge clk);
                    mux_addr = 3'(c);
                    adc      = 14'(ROW_PEAK[r][c]);
                    if (!(k == 0 && c == 0) && (mux_ch !== meas)) begin
                        fail_value("muxing_channels_o", 32'(mux_ch), 32'(meas));
                    end
                end
            end
        end
        @(negedge clk);
        noise_sample(n);
        mux_addr = 3'd0;
        adc      = n;
        e_cycle  = cycle + 1;
    endtask

    task automatic run_row(input int r, inout logic [31:0] exp_id,
                           inout longint prev_e, inout logic [31:0] prev_t);
        logic [15:0]        cls;
        bit                 pos;
        bit                 neg;
        longint             e_cycle;
        int                 rise_at;
        int                 high;
        logic [31:0]        t;
        logic signed [13:0] n;
        longint             us;
        cls = model_class(r, pos, neg);
        if (cls !== ROW_CLS[r] || pos !== ROW_POS[r]) begin
            fail_text($sformatf("row %0d table disagrees with band rules", r));
        end
        bus_write(32'(`FADS_A_ENABLED), 32'(ROW_EN[r]));
        drive_droplet(r, e_cycle);
        rise_at = -1;
        high    = 0;
        // window covers delay, pulse and the release of acquisition
        for (int k = 1; k <= DELAY + DUR + 8; k++) begin
            @(negedge clk);
            noise_sample(n);
            adc = n;
            if (trig === 1'b1) begin
                if (rise_at < 0) begin
                    rise_at = k;
                end
                high++;
            end
        end
        stable = 1'b0;
        if (ROW_SORT[r]) begin
            if (rise_at - 1 != DELAY + 2) begin
                fail_value("sort_trig_o rise cycle", 32'(rise_at - 1), 32'(DELAY + 2));
            end
            if (high != DUR) begin
                fail_value("sort_trig_o high cycles", 32'(high), 32'(DUR));
            end
        end else if (high != 0) begin
            fail_text("sort_trig_o pulsed for a droplet that is not positive");
        end
        if (pos || neg) begin
            exp_id++;
            read_check("rec id", 32'(`FADS_A_REC_ID), exp_id);
            read_check("rec intensity", 32'(`FADS_A_REC_INT), 32'(ROW_PEAK[r][0]));
            read_check("rec width", 32'(`FADS_A_REC_WIDTH), 32'(ROW_N[r]));
            read_check("rec class", 32'(`FADS_A_REC_CLASS), {16'b0, cls});
            bus_read(32'(`FADS_A_REC_TIME), t);
            if (prev_e >= 0) begin
                us = (e_cycle - prev_e) / `FADS_US_TICKS;
                if (longint'(t - prev_t) < us - 1 || longint'(t - prev_t) > us + 1) begin
                    fail_value("rec time_us step", t - prev_t, 32'(us));
                end
            end
            prev_e = e_cycle;
            prev_t = t;
        end else begin
            read_check("rec id", 32'(`FADS_A_REC_ID), exp_id);
        end
    endtask

    initial begin
        logic [31:0] exp_id;
        longint      prev_e;
        logic [31:0] prev_t;
        adc       = '0;
        mux_addr  = '0;
        stable    = 1'b0;
        sys_addr  = '0;
        sys_wdata = '0;
        wen       = 1'b0;
        ren       = 1'b0;
        lfsr      = 16'd37516;
        errors    = 0;
        test_err  = 0;
        tests_ok  = 0;
        tests_bad = 0;
        exp_id    = '0;
        prev_e    = -1;
        prev_t    = '0;
        @(negedge clk);
        while (rst) @(negedge clk);

        for (int b = 0; b < `FADS_THR_BANKS; b++) begin
            for (int c = 0; c < `FADS_CHNL; c++) begin
                read_check($sformatf("thr bank %0d ch %0d", b, c), thr_addr(b, c),
                           thr_default(b));
            end
        end
        read_check("enabled", 32'(`FADS_A_ENABLED), 32'(`FADS_DEF_ENABLED));
        read_check("sense", 32'(`FADS_A_SENSE), 32'(`FADS_DEF_SENSE));
        read_check("sort delay", 32'(`FADS_A_SORT_DELAY), `FADS_DEF_DELAY);
        read_check("sort duration", 32'(`FADS_A_SORT_DUR), `FADS_DEF_DUR);
        read_check("unmapped", 32'h0000_0500, 32'h0);
        read_check("rec id", 32'(`FADS_A_REC_ID), 32'h0);
        end_test("reset defaults");

        for (int c = 0; c < `FADS_CHNL; c++) begin
            bus_write(thr_addr(0, c), 32'(T_IMIN));
            bus_write(thr_addr(1, c), 32'(T_ILOW));
            bus_write(thr_addr(2, c), 32'(T_IHIGH));
            bus_write(thr_addr(3, c), 32'(T_WMIN));
            bus_write(thr_addr(4, c), 32'(T_WLOW));
            bus_write(thr_addr(5, c), 32'(T_WHIGH));
        end
        bus_write(32'(`FADS_A_SORT_DELAY), 32'(DELAY));
        bus_write(32'(`FADS_A_SORT_DUR), 32'(DUR));
        read_check("thr int high ch 2", thr_addr(2, 2), 32'(T_IHIGH));
        read_check("thr wid low ch 5", thr_addr(4, 5), 32'(T_WLOW));
        read_check("sort delay", 32'(`FADS_A_SORT_DELAY), 32'(DELAY));
        end_test("register write");

        for (int r = 0; r < ROWS; r++) begin
            run_row(r, exp_id, prev_e, prev_t);
            end_test($sformatf("droplet row %0d", r));
        end

        $display("tests: %0d ok, %0d failing, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // limit from the summed row lengths plus bus traffic
    initial begin
        int limit;
        limit = 2000;
        for (int r = 0; r < ROWS; r++) begin
            limit += IDLE + ROW_N[r] * 6 + DELAY + DUR + 60;
        end
        #(limit * 8);
        $display("watchdog: run exceeded %0d cycles", limit);
        $display("tests failed");
        $finish;
    end

endmodule

//--- files.f
+incdir+verilog
verilog/fads_pkg.sv
verilog/fads_regs.sv
verilog/fads_acquire.sv
verilog/fads_evaluate.sv
verilog/fads_sort_pulse.sv
verilog/fads_top.sv
testbench/tb_clock.sv
testbench/tb_fads.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fads
FLIST     ?= files.f
BUILD     ?= obj_dir
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
